// ==== design/misc_regs.sv ====
/* misc register slave
   leds, clock generator, test */

`timescale 1ns/1ns
`default_nettype none

`include "u1plus_config.svh"

module misc_regs
   import u1plus_pkg::*;
(
   input  wire           wb_clk,
   input  wire           wb_rst,
   input  wire           stb_i,
   input  wire           we_i,
   input  wire wb_adr_t  adr_i,
   input  wire wb_data_t dat_i,
   output wb_data_t      dat_o,
   output logic          ack_o,
   input  wire           cgen_st_status_i,
   input  wire           cgen_st_ld_i,
   input  wire           cgen_st_refmon_i,
   output logic [2:0]    leds_o,
   output logic          cgen_sync_b_o,
   output logic          cgen_ref_sel_o
);

   wb_data_t  reg_leds;
   wb_data_t  reg_cgen_ctrl;
   wb_data_t  reg_test;
   misc_reg_e offset;
   logic      wr_en;

   assign offset = misc_reg_e'(adr_i[6:0]);
   assign wr_en  = stb_i & we_i & ack_o;   // commit on the ack edge

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;            // single pulse per access
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= wb_data_t'(2'b11);  // sync_b high, ref_sel high
         reg_test      <= '0;
      end
      else if (wr_en)
      begin
         case (offset)
            misc_leds:      reg_leds      <= dat_i;
            misc_cgen_ctrl: reg_cgen_ctrl <= dat_i;
            misc_test:      reg_test      <= dat_i;
            default:        ;                 // status is read only
         endcase
      end
   end

   ////////////////////
   // readback

   always_comb
   begin
      case (offset)
         misc_leds:      dat_o = reg_leds;
         misc_cgen_ctrl: dat_o = reg_cgen_ctrl;
         misc_cgen_st:   dat_o = {{(`U1_DW-3){1'b0}}, cgen_st_status_i,
                                  cgen_st_ld_i, cgen_st_refmon_i};
         misc_test:      dat_o = reg_test;
         default:        dat_o = `U1_MISC_DEFAULT;
      endcase
   end

   // board wiring swaps led0 and led1
   assign leds_o         = {reg_leds[2], reg_leds[0], reg_leds[1]};
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   a_ack_after_stb: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $rose(ack_o) |-> $past(stb_i))
      else $error("misc ack without a prior strobe");

endmodule

`default_nettype wire

// ==== design/settings_bridge.sv ====
/* 16-bit wishbone to 32-bit settings bus */

`timescale 1ns/1ns
`default_nettype none

`include "u1plus_config.svh"

module settings_bridge
   import u1plus_pkg::*;
(
   input  wire           wb_clk,
   input  wire           wb_rst,
   input  wire           stb_i,
   input  wire           we_i,
   input  wire wb_adr_t  adr_i,
   input  wire wb_data_t dat_i,
   output logic          ack_o,
   output logic          set_stb_o,
   output set_addr_t     set_addr_o,
   output set_data_t     set_data_o
);

   bridge_state_e state;
   wb_data_t      low_q;      // low half waiting for its partner
   logic          wr_ack;
   logic          hi_half;

   assign wr_ack  = stb_i & we_i & ack_o;
   assign hi_half = adr_i[1];

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;
   end

   ////////////////////
   // half-word pairing

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         state     <= br_idle;
         set_stb_o <= 1'b0;
      end
      else
      begin
         set_stb_o <= 1'b0;
         if (wr_ack)
         begin
            if (!hi_half)
               state <= br_high_pending;
            else
            begin
               state     <= br_idle;
               set_stb_o <= (state == br_high_pending);  // orphan high half dropped
            end
         end
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_ack)
      begin
         if (!hi_half)
            low_q <= dat_i;
         else
         begin
            set_data_o <= {dat_i, low_q};
            set_addr_o <= set_addr_t'(adr_i[2 +: `U1_SET_RWIDTH]);
         end
      end
   end

   a_stb_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb_o |=> !set_stb_o)
      else $error("settings strobe held for two cycles");

endmodule

`default_nettype wire

// ==== design/u1plus_ctrl_top.sv ====
/* u1plus control plane top */

`timescale 1ns/1ns
`default_nettype none

`include "u1plus_config.svh"

module u1plus_ctrl_top
   import u1plus_pkg::*;
(
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   // host wishbone
   input  wire                   wb_cyc_i,
   input  wire                   wb_stb_i,
   input  wire                   wb_we_i,
   input  wire wb_adr_t          wb_adr_i,
   input  wire [`U1_DW/8-1:0]    wb_sel_i,
   input  wire wb_data_t         wb_dat_i,
   output wb_data_t              wb_dat_o,
   output logic                  wb_ack_o,
   // board pins
   input  wire                   cgen_st_status_i,
   input  wire                   cgen_st_ld_i,
   input  wire                   cgen_st_refmon_i,
   input  wire                   pps_i,
   output logic [2:0]            leds_o,
   output logic                  cgen_sync_b_o,
   output logic                  cgen_ref_sel_o,
   output vita_time_t            vita_time_o,
   output logic                  pps_int_o
);

   logic      misc_stb, misc_ack;
   wb_data_t  misc_dat;
   logic      bridge_stb, bridge_ack;
   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;

   wb_slave_decoder decoder_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_adr_i(wb_adr_i),
      .misc_stb_o(misc_stb), .set_stb_o(bridge_stb),
      .misc_dat_i(misc_dat), .set_dat_i('0),       // settings slot is write only
      .misc_ack_i(misc_ack), .set_ack_i(bridge_ack),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o));

   misc_regs misc_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(misc_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .dat_o(misc_dat), .ack_o(misc_ack),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .leds_o(leds_o), .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   settings_bridge bridge_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(bridge_stb), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .ack_o(bridge_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   vita_timekeeper time_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time_o), .pps_int_o(pps_int_o));

   // 16-bit slaves only, no byte lane writes
   a_full_word: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_cyc_i && wb_stb_i |-> &wb_sel_i)
      else $error("partial byte select on the host bus");

endmodule

`default_nettype wire

// ==== design/u1plus_pkg.sv ====
/* u1plus control plane types */

`default_nettype none

`include "u1plus_config.svh"

package u1plus_pkg;

   typedef logic [`U1_DW-1:0] wb_data_t;
   typedef logic [`U1_AW-1:0] wb_adr_t;
   typedef logic [7:0]        set_addr_t;
   typedef logic [31:0]       set_data_t;

   // seconds on top, ticks below
   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   typedef enum logic [1:0] {
      slot_misc,
      slot_settings,
      slot_unmapped    // answers with zero data
   } wb_slot_e;

   typedef enum logic [6:0] {
      misc_leds      = 7'(`U1_REG_LEDS),
      misc_cgen_ctrl = 7'(`U1_REG_CGEN_CTRL),
      misc_cgen_st   = 7'(`U1_REG_CGEN_ST),
      misc_test      = 7'(`U1_REG_TEST)
   } misc_reg_e;

   typedef enum logic {
      br_idle,
      br_high_pending
   } bridge_state_e;

   // offsets from the timekeeper base
   typedef enum logic [1:0] {
      time_ticks  = 2'd0,
      time_secs   = 2'd1,
      time_commit = 2'd2
   } time_reg_e;

endpackage

`default_nettype wire

// ==== design/vita_timekeeper.sv ====
/* 64-bit vita time counter
   with pps aligned load */

`timescale 1ns/1ns
`default_nettype none

`include "u1plus_config.svh"

module vita_timekeeper
   import u1plus_pkg::*;
(
   input  wire            wb_clk,
   input  wire            wb_rst,
   input  wire            set_stb_i,
   input  wire set_addr_t set_addr_i,
   input  wire set_data_t set_data_i,
   input  wire            pps_i,
   output vita_time_t     vita_time_o,
   output logic           pps_int_o
);

   localparam logic [31:0] TICKS_MAX = 32'(`U1_TICKS_PER_SEC - 1);

   set_addr_t   rel_addr;
   time_reg_e   reg_sel;
   logic        hit;
   logic        commit;
   logic        load_now;
   logic        load_pps;
   logic [31:0] new_ticks;
   logic [31:0] new_secs;
   logic [2:0]  pps_sh;      // two sync stages plus edge history
   logic        pps_rise;
   logic        pps_armed;

   ////////////////////
   // settings decode

   assign rel_addr = set_addr_i - set_addr_t'(`U1_SR_TIME64);
   assign reg_sel  = time_reg_e'(rel_addr[1:0]);
   assign hit      = set_stb_i & (rel_addr[7:2] == '0);
   assign commit   = hit & (reg_sel == time_commit);
   assign load_now = commit & set_data_i[0];       // bit 0 set means load now
   assign load_pps = pps_armed & pps_rise;

   always_ff @(posedge wb_clk)
   begin
      if (hit)
      begin
         case (reg_sel)
            time_ticks: new_ticks <= set_data_i;
            time_secs:  new_secs  <= set_data_i;
            default:    ;
         endcase
      end
   end

   ////////////////////
   // pps sync and edge

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sh    <= '0;
         pps_int_o <= 1'b0;
         pps_armed <= 1'b0;
      end
      else
      begin
         pps_sh    <= {pps_sh[1:0], pps_i};
         pps_int_o <= pps_rise;
         if (commit)
            pps_armed <= ~set_data_i[0];
         else if (pps_rise)
            pps_armed <= 1'b0;                     // one shot
      end
   end

   assign pps_rise = pps_sh[1] & ~pps_sh[2];

   ////////////////////
   // counter

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         vita_time_o <= '0;
      else if (load_now || load_pps)
      begin
         vita_time_o.secs  <= new_secs;
         vita_time_o.ticks <= new_ticks;
      end
      else if (vita_time_o.ticks >= TICKS_MAX)
      begin
         vita_time_o.ticks <= '0;
         vita_time_o.secs  <= vita_time_o.secs + 32'd1;
      end
      else
         vita_time_o.ticks <= vita_time_o.ticks + 32'd1;
   end

endmodule

`default_nettype wire

// ==== design/wb_slave_decoder.sv ====
/* wishbone slot decoder, single master */

`timescale 1ns/1ns
`default_nettype none

`include "u1plus_config.svh"

module wb_slave_decoder
   import u1plus_pkg::*;
(
   input  wire           wb_clk,
   input  wire           wb_rst,
   input  wire           wb_cyc_i,
   input  wire           wb_stb_i,
   input  wire wb_adr_t  wb_adr_i,
   output logic          misc_stb_o,
   output logic          set_stb_o,
   input  wire wb_data_t misc_dat_i,
   input  wire wb_data_t set_dat_i,
   input  wire           misc_ack_i,
   input  wire           set_ack_i,
   output wb_data_t      wb_dat_o,
   output logic          wb_ack_o
);

   logic [`U1_DECODE_W-1:0] slot_num;
   wb_slot_e                slot;
   logic                    host_req;
   logic                    unmap_stb;
   logic                    unmap_ack;

   assign slot_num = wb_adr_i[`U1_AW-1 -: `U1_DECODE_W];
   assign host_req = wb_cyc_i & wb_stb_i;

   always_comb
   begin
      case (slot_num)
         `U1_DECODE_W'(`U1_SLOT_MISC):     slot = slot_misc;
         `U1_DECODE_W'(`U1_SLOT_SETTINGS): slot = slot_settings;
         default:                          slot = slot_unmapped;
      endcase
   end

   assign misc_stb_o = host_req & (slot == slot_misc);
   assign set_stb_o  = host_req & (slot == slot_settings);
   assign unmap_stb  = host_req & (slot == slot_unmapped);

   // empty slots still ack so the host never stalls
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         unmap_ack <= 1'b0;
      else
         unmap_ack <= unmap_stb & ~unmap_ack;
   end

   ////////////////////
   // return path

   always_comb
   begin
      case (slot)
         slot_misc:     wb_dat_o = misc_dat_i;
         slot_settings: wb_dat_o = set_dat_i;
         default:       wb_dat_o = '0;
      endcase
      case (slot)
         slot_misc:     wb_ack_o = misc_ack_i;
         slot_settings: wb_ack_o = set_ack_i;
         default:       wb_ack_o = unmap_ack;
      endcase
   end

   a_one_strobe: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({misc_stb_o, set_stb_o, unmap_stb}))
      else $error("more than one slave strobe active");

   // each slave must answer in the cycle after the request
   a_ack_next: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $rose(host_req) |=> wb_ack_o)
      else $error("slave ack missing one cycle after strobe");

endmodule

`default_nettype wire

// ==== include/u1plus_config.svh ====
/* u1plus control plane
   configuration constants */

`ifndef U1PLUS_CONFIG_SVH
`define U1PLUS_CONFIG_SVH

////////////////////
// wishbone geometry

`define U1_DW           16
`define U1_AW           11
`define U1_DECODE_W     4      // top address bits pick the slot

////////////////////
// slot map, kept from the full core

`define U1_SLOT_MISC     0
`define U1_SLOT_SETTINGS 5

////////////////////
// misc slave, byte offsets in the low 7 address bits

`define U1_REG_LEDS      0
`define U1_REG_CGEN_CTRL 4
`define U1_REG_CGEN_ST   6     // read only
`define U1_REG_TEST      8
`define U1_MISC_DEFAULT  16'hBEEF

////////////////////
// settings bus and timekeeper

`define U1_SR_TIME64     28    // ticks, secs, commit
`define U1_TICKS_PER_SEC 64000000
`define U1_SET_RWIDTH    5     // 32 settings registers

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the u1plus control plane simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
   --timescale 1ns/1ns \
   -f u1plus_ctrl.f \
   --top-module tb_u1plus_ctrl \
   -o sim_u1plus_ctrl

./obj_dir/sim_u1plus_ctrl

// ==== testbench/tb_u1plus_tasks.svh ====
/* testbench bus tasks and reference model */

`ifndef TB_U1PLUS_TASKS_SVH
`define TB_U1PLUS_TASKS_SVH

// fibonacci lfsr, taps 16 14 13 11
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] r;
   logic        fb;
   r = '0;
   for (int i = 0; i < n; i++)
   begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
   end
   return r;
endfunction

////////////////////
// reference model

function automatic wb_data_t ref_misc_read(input logic [6:0] off, input logic [2:0] st);
   case (off)
      7'(`U1_REG_LEDS):      return model_leds;
      7'(`U1_REG_CGEN_CTRL): return model_ctrl;
      7'(`U1_REG_CGEN_ST):   return wb_data_t'(st);   // status, ld, refmon
      7'(`U1_REG_TEST):      return model_test;
      default:               return `U1_MISC_DEFAULT;
   endcase
endfunction

// led1 on bit 0, led0 on bit 1
function automatic logic [2:0] ref_leds(input wb_data_t r);
   return {r[2], r[0], r[1]};
endfunction

function automatic vita_time_t ref_time(input vita_time_t t, input int n);
   vita_time_t r;
   r = t;
   for (int i = 0; i < n; i++)
   begin
      if (r.ticks >= TPS - 32'd1)
      begin
         r.ticks = '0;
         r.secs  = r.secs + 32'd1;
      end
      else
         r.ticks = r.ticks + 32'd1;
   end
   return r;
endfunction

////////////////////
// compare tasks

task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
   if (got !== exp)
   begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

task automatic check_leds(input string name, input logic [2:0] got, input logic [2:0] exp);
   if (got !== exp)
   begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

task automatic check_time(input string name, input vita_time_t got, input vita_time_t exp);
   if (got !== exp)
   begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

task automatic check_pins();
   check_leds("leds_o", leds_o, ref_leds(model_leds));
   check_word("cgen pins", wb_data_t'({cgen_sync_b_o, cgen_ref_sel_o}),
              model_ctrl & 16'h0003);
endtask

////////////////////
// host bus

function automatic wb_adr_t misc_adr(input logic [6:0] off);
   return {`U1_DECODE_W'(`U1_SLOT_MISC), off};
endfunction

function automatic wb_adr_t set_adr(input int idx, input logic hi);
   return {`U1_DECODE_W'(`U1_SLOT_SETTINGS), `U1_SET_RWIDTH'(idx), hi, 1'b0};
endfunction

function automatic logic [2:0] st_pins();
   return {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
endfunction

// starts 10 ns after an edge, returns 10 ns after the ack edge
task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t dat);
   int waited;
   @(posedge wb_clk);
   #10;
   wb_cyc_i = 1'b1;
   wb_stb_i = 1'b1;
   wb_we_i  = we;
   wb_adr_i = adr;
   wb_dat_i = dat;
   access_count++;
   waited = 0;
   do
   begin
      @(posedge wb_clk);
      #1;
      waited++;
   end while (!wb_ack_o && waited < 8);
   if (!wb_ack_o)
   begin
      $display("no ack within 8 cycles at address 0x%h", adr);
      abort_run();
   end
   if (waited != 1)
   begin
      $display("ack came %0d cycles after strobe instead of one", waited);
      abort_run();
   end
   @(posedge wb_clk);
   #10;
   wb_cyc_i = 1'b0;
   wb_stb_i = 1'b0;
   wb_we_i  = 1'b0;
endtask

task automatic wb_write(input wb_adr_t adr, input wb_data_t dat);
   wb_access(1'b1, adr, dat);
endtask

task automatic wb_read(input wb_adr_t adr, input wb_data_t exp);
   exp_q.push_back(exp);      // checked by the ack monitor
   wb_access(1'b0, adr, '0);
endtask

task automatic settings_write(input int idx, input set_data_t d);
   wb_write(set_adr(idx, 1'b0), d[15:0]);
   wb_write(set_adr(idx, 1'b1), d[31:16]);
endtask

task automatic load_time(input vita_time_t t, input logic now);
   settings_write(`U1_SR_TIME64 + int'(time_ticks), t.ticks);
   settings_write(`U1_SR_TIME64 + int'(time_secs), t.secs);
   settings_write(`U1_SR_TIME64 + int'(time_commit), set_data_t'(now));
endtask

// load edge, then n more cycles
task automatic run_and_check(input vita_time_t t0, input int n);
   @(posedge wb_clk);
   repeat (n) @(posedge wb_clk);
   @(negedge wb_clk);
   check_time("vita_time_o", vita_time_o, ref_time(t0, n));
endtask

`endif

// ==== testbench/tb_u1plus_ctrl.sv ====
/* u1plus control plane testbench */

`timescale 1ns/1ns
`default_nettype none

`include "u1plus_config.svh"

module tb_u1plus_ctrl
   import u1plus_pkg::*;
();

   localparam int          NUM_TESTS       = 5;
   localparam int          CYCLES_PER_TEST = 200;
   localparam logic [31:0] TPS             = 32'(`U1_TICKS_PER_SEC);

   logic        wb_clk;
   logic        wb_rst;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   wb_adr_t     wb_adr_i;
   logic [1:0]  wb_sel_i;
   wb_data_t    wb_dat_i;
   wb_data_t    wb_dat_o;
   logic        wb_ack_o;
   logic        cgen_st_status_i;
   logic        cgen_st_ld_i;
   logic        cgen_st_refmon_i;
   logic        pps_i;
   logic [2:0]  leds_o;
   logic        cgen_sync_b_o;
   logic        cgen_ref_sel_o;
   vita_time_t  vita_time_o;
   logic        pps_int_o;

   wb_data_t    model_leds;
   wb_data_t    model_ctrl;
   wb_data_t    model_test;
   logic [15:0] lfsr_q;
   wb_data_t    exp_q[$];     // expected read data in bus order
   int          access_count = 0;
   int          ack_count    = 0;
   logic        ack_last     = 1'b0;
   int          cyc_count    = 0;

   u1plus_ctrl_top dut_i (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_sel_i(wb_sel_i), .wb_dat_i(wb_dat_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .pps_i(pps_i),
      .leds_o(leds_o), .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .vita_time_o(vita_time_o), .pps_int_o(pps_int_o));

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first failure");
   endtask

   `include "tb_u1plus_tasks.svh"

   initial wb_clk = 1'b0;
   always #50 wb_clk = ~wb_clk;   // 100 ns period

   always @(posedge wb_clk)
      cyc_count++;                // read at falling edges only

   initial
   begin
      repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge wb_clk);
      $display("watchdog expired after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
      abort_run();
   end

   ////////////////////
   // ack monitor, mid cycle

   always @(negedge wb_clk)
   begin
      if (!wb_rst && wb_ack_o)
      begin
         if (ack_last)
         begin
            $display("wb_ack_o stayed high for two cycles");
            abort_run();
         end
         ack_count++;
         if (!wb_we_i && exp_q.size() == 0)
         begin
            $display("read ack with no expected value queued");
            abort_run();
         end
         else if (!wb_we_i)
            check_word("wb_dat_o", wb_dat_o, exp_q.pop_front());
      end
      ack_last = wb_ack_o;
   end

   initial
   begin
      vita_time_t t_load;
      vita_time_t t_prev;
      wb_data_t   d;
      logic [6:0] off;
      int         n;
      int         mark_cyc;
      bit         seen;

      wb_rst           = 1'b1;
      wb_cyc_i         = 1'b0;
      wb_stb_i         = 1'b0;
      wb_we_i          = 1'b0;
      wb_adr_i         = '0;
      wb_sel_i         = 2'b11;
      wb_dat_i         = '0;
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i     = 1'b0;
      cgen_st_refmon_i = 1'b0;
      pps_i            = 1'b0;
      lfsr_q           = 16'd47;
      model_leds       = '0;
      model_ctrl       = 16'h0003;   // sync_b and ref_sel high
      model_test       = '0;
      repeat (3) @(posedge wb_clk);
      #10;
      wb_rst = 1'b0;

      // reset values
      wb_read(misc_adr(7'(`U1_REG_LEDS)), ref_misc_read(7'(`U1_REG_LEDS), st_pins()));
      wb_read(misc_adr(7'(`U1_REG_CGEN_CTRL)), ref_misc_read(7'(`U1_REG_CGEN_CTRL), st_pins()));
      wb_read(misc_adr(7'(`U1_REG_TEST)), ref_misc_read(7'(`U1_REG_TEST), st_pins()));
      check_pins();

      // random register traffic
      for (int i = 0; i < 8; i++)
      begin
         n   = int'(rand_bits(4) % 3);
         off = (n == 0) ? 7'(`U1_REG_LEDS) : (n == 1) ? 7'(`U1_REG_CGEN_CTRL) : 7'(`U1_REG_TEST);
         d   = wb_data_t'(rand_bits(16));
         wb_write(misc_adr(off), d);
         if (n == 0)
            model_leds = d;
         else if (n == 1)
            model_ctrl = d;
         else
            model_test = d;
         wb_read(misc_adr(off), ref_misc_read(off, st_pins()));
         check_pins();
      end

      // status, default offsets, empty slots
      for (int i = 0; i < 4; i++)
      begin
         {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} = 3'(rand_bits(3));
         wb_read(misc_adr(7'(`U1_REG_CGEN_ST)), ref_misc_read(7'(`U1_REG_CGEN_ST), st_pins()));
      end
      wb_read(misc_adr(7'd2), ref_misc_read(7'd2, st_pins()));
      wb_read(misc_adr(7'h7E), ref_misc_read(7'h7E, st_pins()));
      wb_read({4'd3, 7'd0}, '0);
      wb_write({4'd9, 7'd4}, 16'h1234);
      wb_read({4'd15, 7'h7F}, '0);

      // immediate load, then a load just short of the wrap
      t_load.secs  = rand_bits(32);
      t_load.ticks = rand_bits(32) % TPS;
      load_time(t_load, 1'b1);
      run_and_check(t_load, 4 + int'(rand_bits(3)));
      t_load.secs  = rand_bits(32);
      t_load.ticks = TPS - 32'd3;
      load_time(t_load, 1'b1);
      run_and_check(t_load, 5);
      t_prev   = ref_time(t_load, 5);   // model time at this falling edge
      mark_cyc = cyc_count;

      // load armed for the next pps edge
      t_load.secs  = rand_bits(32);
      t_load.ticks = rand_bits(32) % TPS;
      load_time(t_load, 1'b0);
      @(posedge wb_clk);
      #10;
      pps_i = 1'b1;
      seen  = 1'b0;
      for (int i = 0; i < 8 && !seen; i++)
      begin
         @(negedge wb_clk);
         if (pps_int_o)
            seen = 1'b1;
         else
         begin
            // still free running
            check_time("vita_time_o", vita_time_o, ref_time(t_prev, cyc_count - mark_cyc));
         end
      end
      if (!seen)
      begin
         $display("pps_int_o did not pulse after the pps edge");
         abort_run();
      end
      check_time("vita_time_o", vita_time_o, t_load);
      for (int i = 1; i < 6; i++)
      begin
         @(negedge wb_clk);
         if (pps_int_o)
         begin
            $display("pps_int_o pulsed again with pps held high");
            abort_run();
         end
         check_time("vita_time_o", vita_time_o, ref_time(t_load, i));
      end

      if (exp_q.size() == 0 && ack_count == access_count)
      begin
         $display("Simulation finished: PASS");
         $finish;
      end
      else
      begin
         $display("%0d accesses got %0d acks, %0d reads unanswered",
                  access_count, ack_count, exp_q.size());
         abort_run();
      end
   end

endmodule

`default_nettype wire

// ==== u1plus_ctrl.f ====
+incdir+include
+incdir+testbench
design/u1plus_pkg.sv
design/wb_slave_decoder.sv
design/misc_regs.sv
design/settings_bridge.sv
design/vita_timekeeper.sv
design/u1plus_ctrl_top.sv
testbench/tb_u1plus_ctrl.sv
